// ==== hdl/lsu_pkg.sv ====
// Shared widths, RV32I encodings and records of the load/store unit.
// XLEN is fixed at 32 and the AXI4-Lite data bus has the same width.
package lsu_pkg;

    //////////////////////
    // Widths
    //////////////////////

    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8;

    //////////////////////
    // Encodings
    //////////////////////

    // Major opcodes served here
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Access size, bit 2 selects zero extension on loads
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    //////////////////////
    // Records
    //////////////////////

    // Instruction as delivered by the issue stage
    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [11:0]     imm12;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } lsu_instr_t;

    // Misalignment report with the faulting address
    typedef struct packed {
        logic            load_misaligned;
        logic            store_misaligned;
        logic [XLEN-1:0] addr;
    } lsu_exc_t;

    // What a load needs to format its completion
    typedef struct packed {
        logic [4:0] rd;
        logic [2:0] funct3;
        logic [1:0] offset;
    } lsu_ld_ctx_t;

    // Destination register write
    typedef struct packed {
        logic            wr;
        logic [4:0]      addr;
        logic [XLEN-1:0] val;
    } lsu_rd_t;

    // Decoded request, decode to execute
    typedef struct packed {
        logic              is_load;
        logic              is_store;
        logic              misaligned;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
        lsu_ld_ctx_t       ld_ctx;
    } lsu_req_t;

endpackage

// ==== hdl/lsu_decode.sv ====
// Purely combinational; opcodes other than LOAD and STORE decode to no request.
`timescale 1ns/1ps

module lsu_decode
    import lsu_pkg::*;
(
    input  lsu_instr_t instr,
    output lsu_req_t   req
);

    logic [XLEN-1:0]   addr;
    logic [1:0]        offset;
    logic              is_load;
    logic              is_store;
    logic [STRB_W-1:0] size_mask;
    logic [2*XLEN-1:0] rot_dbl;

    //////////////////////
    // Address
    //////////////////////

    // rs1 plus sign-extended immediate
    assign addr   = instr.rs1_val + {{(XLEN-12){instr.imm12[11]}}, instr.imm12};
    assign offset = addr[1:0];

    assign is_load  = (instr.opcode == OPCODE_LOAD);
    assign is_store = (instr.opcode == OPCODE_STORE);

    //////////////////////
    // Store lane
    //////////////////////

    // Byte, half or word mask before lane shift
    always_comb begin
        case (instr.funct3[1:0])
            F3_B[1:0]: size_mask = {{(STRB_W-1){1'b0}}, 1'b1};
            F3_H[1:0]: size_mask = {{(STRB_W-2){1'b0}}, 2'b11};
            default:   size_mask = {STRB_W{1'b1}};
        endcase
    end

    // Upper half of the doubled word is the left rotation
    assign rot_dbl = {instr.rs2_val, instr.rs2_val} << {offset, 3'b000};

    //////////////////////
    // Request
    //////////////////////

    always_comb begin
        req.is_load  = is_load;
        req.is_store = is_store;
        // Half at odd offset, word at any non-zero offset
        case (instr.funct3[1:0])
            F3_H[1:0]: req.misaligned = (is_load | is_store) & offset[0];
            F3_W[1:0]: req.misaligned = (is_load | is_store) & (offset != 2'b00);
            default:   req.misaligned = 1'b0;
        endcase
        req.addr  = addr;
        req.wdata = rot_dbl[2*XLEN-1 -: XLEN];
        // Strobes only mean something for stores
        req.wstrb = is_store ? (size_mask << offset) : {STRB_W{1'b0}};
        req.ld_ctx.rd     = instr.rd;
        req.ld_ctx.funct3 = instr.funct3;
        req.ld_ctx.offset = offset;
    end

endmodule

// ==== hdl/lsu_execute.sv ====
// Single-ID ordering: one direction drains before the other issues.
// Counters count from acceptance to completion; at most MAX_OR per direction.
`timescale 1ns/1ps

module lsu_execute
    import lsu_pkg::*;
#(
    parameter int MAX_OR = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  lsu_req_t          req,
    output lsu_exc_t          exc,
    output logic              ld_push,
    output lsu_ld_ctx_t       ld_ctx,
    input  logic              ld_full,
    output logic              awvalid,
    input  logic              awready,
    output logic [XLEN-1:0]   awaddr,
    output logic              wvalid,
    input  logic              wready,
    output logic [XLEN-1:0]   wdata,
    output logic [STRB_W-1:0] wstrb,
    input  logic              bvalid,
    output logic              arvalid,
    input  logic              arready,
    output logic [XLEN-1:0]   araddr,
    input  logic              rvalid,
    output logic              pending_read,
    output logic              pending_write
);

    localparam int CNT_W = $clog2(MAX_OR + 1);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WAIT  = 2'd1,
        SERVE = 2'd2
    } state_t;

    state_t            state;
    logic              pend_load;
    logic [XLEN-1:0]   req_addr;
    logic [CNT_W-1:0]  rd_cnt;
    logic [CNT_W-1:0]  wr_cnt;
    logic              accept;
    logic              issue;
    logic              block;
    logic              done;
    logic              wr_push;

    //////////////////////
    // Acceptance
    //////////////////////

    // Every raised valid sees its ready this cycle
    assign done = (!awvalid || awready) && (!wvalid || wready) && (!arvalid || arready);

    assign instr_ready = (state == IDLE || (state == SERVE && done)) && !ld_full
                         && (rd_cnt != MAX_OR[CNT_W-1:0]) && (wr_cnt != MAX_OR[CNT_W-1:0]);

    assign accept  = instr_valid && instr_ready;
    assign issue   = accept && (req.is_load || req.is_store) && !req.misaligned;
    assign ld_push = issue && req.is_load;
    assign wr_push = issue && req.is_store;
    assign ld_ctx  = req.ld_ctx;

    // Opposite direction still has traffic in flight
    assign block = req.is_load ? (wr_cnt != '0) : (rd_cnt != '0);

    // Flags live only in the accepting cycle
    assign exc.load_misaligned  = accept && req.is_load && req.misaligned;
    assign exc.store_misaligned = accept && req.is_store && req.misaligned;
    assign exc.addr             = req.addr;

    //////////////////////
    // Request FSM
    //////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= IDLE;
            pend_load <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
        end else begin
            // Drop each channel once it handshakes
            if (awready) awvalid <= 1'b0;
            if (wready)  wvalid  <= 1'b0;
            if (arready) arvalid <= 1'b0;
            case (state)
                WAIT: begin
                    // Raise the held request once the other side drained
                    if (pend_load ? (wr_cnt == '0) : (rd_cnt == '0)) begin
                        state   <= SERVE;
                        arvalid <= pend_load;
                        awvalid <= !pend_load;
                        wvalid  <= !pend_load;
                    end
                end
                default: begin
                    if (issue) begin
                        pend_load <= req.is_load;
                        if (block) begin
                            state <= WAIT;
                        end else begin
                            state   <= SERVE;
                            arvalid <= req.is_load;
                            awvalid <= req.is_store;
                            wvalid  <= req.is_store;
                        end
                    end else if (state == SERVE && done) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Request payload, loaded on acceptance
    always_ff @(posedge aclk) begin
        if (issue) begin
            req_addr <= req.addr;
            wdata    <= req.wdata;
            wstrb    <= req.wstrb;
        end
    end

    assign awaddr = req_addr;
    assign araddr = req_addr;

    //////////////////////
    // Outstanding counters
    //////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else begin
            rd_cnt <= rd_cnt + CNT_W'(ld_push) - CNT_W'(rvalid);
            wr_cnt <= wr_cnt + CNT_W'(wr_push) - CNT_W'(bvalid);
        end
    end

    assign pending_read  = (rd_cnt != '0);
    assign pending_write = (wr_cnt != '0);

    //////////////////////
    // Checks
    //////////////////////

    // Slave may stall, the master may not withdraw
    a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid);
    a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid);
    a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid);

    // Completion without a request in flight
    a_b_cnt: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid |-> wr_cnt != '0);
    a_r_cnt: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid |-> rd_cnt != '0);

endmodule

// ==== hdl/lsu_fifo.sv ====
// Load context FIFO, DEPTH of 2 or more; the output is the stored head only.
`timescale 1ns/1ps

module lsu_fifo
    import lsu_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        push,
    input  lsu_ld_ctx_t din,
    input  logic        pull,
    output lsu_ld_ctx_t dout,
    output logic        full,
    output logic        empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsu_ld_ctx_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pull) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pull);
        end
    end

    always_ff @(posedge aclk) begin
        if (push) mem[wr_ptr] <= din;
    end

    assign dout  = mem[rd_ptr];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn) push |-> !full);
    a_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn) pull |-> !empty);

endmodule

// ==== hdl/lsu_result.sv ====
// Read completions return in issue order, so the FIFO head always matches rdata.
`timescale 1ns/1ps

module lsu_result
    import lsu_pkg::*;
#(
    parameter int MAX_OR = 4
) (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            ld_push,
    input  lsu_ld_ctx_t     ld_ctx,
    output logic            ld_full,
    input  logic            rvalid,
    input  logic [XLEN-1:0] rdata,
    output lsu_rd_t         rd_out
);

    lsu_ld_ctx_t     head;
    logic            ctx_empty;
    logic [XLEN-1:0] shifted;

    // One entry per load in flight
    lsu_fifo #(
        .DEPTH (MAX_OR)
    ) u_ctx_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .push    (ld_push),
        .din     (ld_ctx),
        .pull    (rvalid),
        .dout    (head),
        .full    (ld_full),
        .empty   (ctx_empty)
    );

    //////////////////////
    // Formatting
    //////////////////////

    // Addressed byte down to bit 0
    assign shifted = rdata >> {head.offset, 3'b000};

    always_comb begin
        rd_out.wr   = rvalid && !ctx_empty;
        rd_out.addr = head.rd;
        case (head.funct3)
            F3_B:    rd_out.val = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            F3_BU:   rd_out.val = {{(XLEN-8){1'b0}}, shifted[7:0]};
            F3_H:    rd_out.val = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            F3_HU:   rd_out.val = {{(XLEN-16){1'b0}}, shifted[15:0]};
            // LW and anything else pass the word
            default: rd_out.val = shifted;
        endcase
    end

endmodule

// ==== hdl/lsu_top.sv ====
// Load/store unit, AXI4-Lite master; bresp and rresp are not checked.
// Completions are always accepted and protection is fixed at zero.
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int MAX_OR = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    // Instruction port
    input  logic              instr_valid,
    output logic              instr_ready,
    input  lsu_instr_t        instr,
    output lsu_exc_t          exc,
    output lsu_rd_t           rd_out,
    output logic              pending_read,
    output logic              pending_write,
    // AXI4-Lite write
    output logic              awvalid,
    input  logic              awready,
    output logic [XLEN-1:0]   awaddr,
    output logic [2:0]        awprot,
    output logic              wvalid,
    input  logic              wready,
    output logic [XLEN-1:0]   wdata,
    output logic [STRB_W-1:0] wstrb,
    input  logic              bvalid,
    output logic              bready,
    input  logic [1:0]        bresp,
    // AXI4-Lite read
    output logic              arvalid,
    input  logic              arready,
    output logic [XLEN-1:0]   araddr,
    output logic [2:0]        arprot,
    input  logic              rvalid,
    output logic              rready,
    input  logic [XLEN-1:0]   rdata,
    input  logic [1:0]        rresp
);

    lsu_req_t    req;
    lsu_ld_ctx_t ld_ctx;
    logic        ld_push;
    logic        ld_full;

    lsu_decode u_decode (
        .instr (instr),
        .req   (req)
    );

    lsu_execute #(
        .MAX_OR (MAX_OR)
    ) u_execute (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .req           (req),
        .exc           (exc),
        .ld_push       (ld_push),
        .ld_ctx        (ld_ctx),
        .ld_full       (ld_full),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .pending_read  (pending_read),
        .pending_write (pending_write)
    );

    lsu_result #(
        .MAX_OR (MAX_OR)
    ) u_result (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ld_push (ld_push),
        .ld_ctx  (ld_ctx),
        .ld_full (ld_full),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rd_out  (rd_out)
    );

    // Unprivileged, secure, data access
    assign awprot = 3'b000;
    assign arprot = 3'b000;

    // Never back-pressure responses
    assign bready = 1'b1;
    assign rready = 1'b1;

endmodule

// ==== verification/tb_clock.sv ====
// Free-running testbench clock; reset is released on a falling edge.
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk    = 1'b0;
        aresetn = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // Hold reset for a fixed number of cycles
    initial begin
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

// ==== verification/tb_lsu.sv ====
// Directed tests; the testbench is the instruction source and the AXI4-Lite slave.
// Slave responses are single-cycle pulses driven on the falling edge.
`timescale 1ns/1ps

module tb_lsu
    import lsu_pkg::*;
;

    localparam int MAX_OR      = 4;
    localparam int PERIOD      = 100;
    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 200;

    // One AXI write beat as seen on aw and w
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   data;
        logic [STRB_W-1:0] strb;
    } wbeat_t;

    logic              aclk;
    logic              aresetn;
    logic              instr_valid;
    logic              instr_ready;
    lsu_instr_t        instr;
    lsu_exc_t          exc;
    lsu_rd_t           rd_out;
    logic              pending_read;
    logic              pending_write;
    logic              awvalid;
    logic              awready;
    logic [XLEN-1:0]   awaddr;
    logic [2:0]        awprot;
    logic              wvalid;
    logic              wready;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;
    logic              arvalid;
    logic              arready;
    logic [XLEN-1:0]   araddr;
    logic [2:0]        arprot;
    logic              rvalid;
    logic              rready;
    logic [XLEN-1:0]   rdata;
    logic [1:0]        rresp;

    int          errors;
    int          checks;
    int          tests_run;
    int          test_err0;
    logic [31:0] lfsr;

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(10)) u_clock (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    lsu_top #(.MAX_OR(MAX_OR)) uut (.*);

    //////////////////////
    // Helpers
    //////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    function automatic lsu_instr_t make_instr(input logic [6:0] op, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [11:0] imm,
                                              input logic [31:0] rs1, input logic [31:0] rs2);
        lsu_instr_t ins;
        ins.opcode  = op;
        ins.funct3  = f3;
        ins.rd      = rd;
        ins.imm12   = imm;
        ins.rs1_val = rs1;
        ins.rs2_val = rs2;
        return ins;
    endfunction

    // Byte i of the source lands in lane (i + off) mod 4
    function automatic logic [31:0] lane_data(input logic [31:0] d, input logic [1:0] off);
        logic [31:0] r;
        logic [1:0]  lane;
        for (int i = 0; i < 4; i++) begin
            lane = 2'(i) + off;
            r[lane*8 +: 8] = d[i*8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [3:0] lane_strb(input logic [2:0] f3, input logic [1:0] off);
        logic [3:0] m;
        m = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        return m << off;
    endfunction

    // Select the addressed bytes, then extend by size and sign
    function automatic logic [31:0] load_value(input logic [31:0] d, input logic [2:0] f3,
                                               input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = d[off*8 +: 8];
        h = off[1] ? d[31:16] : d[15:0];
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0, h};
            default: return d;
        endcase
    endfunction

    //////////////////////
    // Compare tasks
    //////////////////////

    task automatic check_rd(input string name, input lsu_rd_t exp, input lsu_rd_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_exc(input string name, input lsu_exc_t exp, input lsu_exc_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_beat(input string name, input wbeat_t exp, input wbeat_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        if (cond !== 1'b1) begin
            errors++;
            $display("Error: %s", what);
        end
    endtask

    task automatic start_test();
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err0)
            $display("[%s] ok", name);
        else
            $display("[%s] %0d mismatches", name, errors - test_err0);
    endtask

    //////////////////////
    // Bus agents
    //////////////////////

    // Present one instruction until accepted, returns on the next falling edge
    task automatic issue_instr(input lsu_instr_t ins, output lsu_exc_t exc_seen);
        @(negedge aclk);
        instr_valid = 1'b1;
        instr       = ins;
        #1;
        while (!instr_ready) begin
            @(negedge aclk);
            #1;
        end
        exc_seen = exc;
        @(negedge aclk);
        instr_valid = 1'b0;
        instr       = '0;
    endtask

    // Takes aw and w, holding awready low for aw_delay cycles
    task automatic serve_write(input int aw_delay, output wbeat_t beat);
        while (!(awvalid && wvalid)) @(negedge aclk);
        check_true("awprot not zero or bready low on a write", awprot == 3'b000 && bready);
        beat.data = wdata;
        beat.strb = wstrb;
        wready    = 1'b1;
        awready   = (aw_delay == 0);
        for (int i = 0; i < aw_delay; i++) begin
            @(negedge aclk);
            wready = 1'b0;
            check_true("awvalid dropped before awready", awvalid);
            check_true("instruction accepted under back-pressure", !instr_ready);
        end
        // Address as it stands in the handshake cycle
        beat.addr = awaddr;
        awready   = 1'b1;
        @(negedge aclk);
        awready = 1'b0;
        wready  = 1'b0;
    endtask

    task automatic complete_b();
        bvalid = 1'b1;
        @(negedge aclk);
        bvalid = 1'b0;
    endtask

    task automatic accept_ar(input string name, input logic [31:0] exp_addr);
        while (!arvalid) @(negedge aclk);
        checks++;
        if (araddr !== exp_addr) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp_addr, araddr);
        end
        check_true("arprot not zero on a read", arprot == 3'b000);
        arready = 1'b1;
        @(negedge aclk);
        arready = 1'b0;
    endtask

    // Register write is sampled while rvalid is high
    task automatic return_r(input logic [31:0] data, output lsu_rd_t got);
        rvalid = 1'b1;
        rdata  = data;
        #1;
        got = rd_out;
        check_true("rready low during a read completion", rready);
        @(negedge aclk);
        rvalid = 1'b0;
    endtask

    //////////////////////
    // Tests
    //////////////////////

    task automatic test_stores();
        lsu_exc_t    e;
        wbeat_t      beat;
        wbeat_t      exp;
        logic [2:0]  f3;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [11:0] imm;
        start_test();
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                f3 = 3'(s);
                if ((s == 1 && off[0]) || (s == 2 && off != 0)) continue;
                rs1 = 32'h2000_0100 + 32'(s * 64);
                // Alternate positive and negative displacements
                imm = off[0] ? 12'hff0 + 12'(off) : 12'h020 + 12'(off);
                rand_word(rs2);
                issue_instr(make_instr(OPCODE_STORE, f3, 5'd0, imm, rs1, rs2), e);
                serve_write(0, beat);
                exp.addr = rs1 + {{20{imm[11]}}, imm};
                exp.data = lane_data(rs2, 2'(off));
                exp.strb = lane_strb(f3, 2'(off));
                check_beat($sformatf("store f3=%0d off=%0d", s, off), exp, beat);
                complete_b();
            end
        end
        end_test("stores");
    endtask

    task automatic test_loads();
        lsu_exc_t    e;
        lsu_rd_t     got;
        lsu_rd_t     exp;
        logic [2:0]  f3s [5];
        logic [31:0] data;
        logic [31:0] addr;
        start_test();
        f3s = '{F3_B, F3_BU, F3_H, F3_HU, F3_W};
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off++) begin
                if ((f3s[k][1:0] == 2'b01 && off[0]) || (f3s[k] == F3_W && off != 0)) continue;
                addr = 32'h3000_0040 + 32'(off);
                rand_word(data);
                issue_instr(make_instr(OPCODE_LOAD, f3s[k], 5'(k * 4 + off + 1), 12'(off),
                                       32'h3000_0040, 32'h0), e);
                accept_ar("load address", addr);
                return_r(data, got);
                exp.wr   = 1'b1;
                exp.addr = 5'(k * 4 + off + 1);
                exp.val  = load_value(data, f3s[k], 2'(off));
                check_rd($sformatf("load f3=%0d off=%0d", f3s[k], off), exp, got);
            end
        end
        end_test("loads");
    endtask

    task automatic test_misaligned();
        lsu_exc_t   e;
        lsu_exc_t   exp;
        logic [6:0] ops [4];
        logic [2:0] f3s [4];
        logic [1:0] offs [4];
        start_test();
        ops  = '{OPCODE_LOAD, OPCODE_LOAD, OPCODE_STORE, OPCODE_STORE};
        f3s  = '{F3_H, F3_W, F3_H, F3_W};
        offs = '{2'd1, 2'd2, 2'd3, 2'd1};
        for (int k = 0; k < 4; k++) begin
            issue_instr(make_instr(ops[k], f3s[k], 5'd7, {10'h0, offs[k]},
                                   32'h4000_0200, 32'hdead_beef), e);
            exp.load_misaligned  = (ops[k] == OPCODE_LOAD);
            exp.store_misaligned = (ops[k] == OPCODE_STORE);
            exp.addr             = 32'h4000_0200 + 32'(offs[k]);
            check_exc($sformatf("misaligned case %0d", k), exp, e);
            repeat (3) begin
                check_true("bus request raised for a misaligned access",
                           !awvalid && !wvalid && !arvalid);
                @(negedge aclk);
            end
        end
        end_test("misaligned");
    endtask

    task automatic test_ordering();
        lsu_exc_t    e;
        wbeat_t      beat;
        lsu_rd_t     got;
        lsu_rd_t     exp;
        logic [31:0] data;
        start_test();
        issue_instr(make_instr(OPCODE_STORE, F3_W, 5'd0, 12'h0, 32'h5000_0000, 32'h1234_5678), e);
        serve_write(0, beat);
        // Write response withheld while the load waits
        issue_instr(make_instr(OPCODE_LOAD, F3_W, 5'd9, 12'h4, 32'h5000_0000, 32'h0), e);
        repeat (5) begin
            check_true("arvalid raised before the write response", !arvalid);
            check_true("pending_write low with a write in flight", pending_write);
            @(negedge aclk);
        end
        complete_b();
        check_true("pending_write still high after the write response", !pending_write);
        rand_word(data);
        accept_ar("ordered load address", 32'h5000_0004);
        return_r(data, got);
        exp.wr   = 1'b1;
        exp.addr = 5'd9;
        exp.val  = data;
        check_rd("ordered load", exp, got);
        end_test("ordering");
    endtask

    task automatic test_backpressure();
        lsu_exc_t e;
        wbeat_t   beat;
        wbeat_t   exp;
        start_test();
        issue_instr(make_instr(OPCODE_STORE, F3_H, 5'd0, 12'h002, 32'h6000_0010, 32'h0000_abcd), e);
        serve_write(4, beat);
        exp.addr = 32'h6000_0012;
        exp.data = 32'habcd_0000;
        exp.strb = 4'b1100;
        check_beat("stalled write beat", exp, beat);
        complete_b();
        end_test("backpressure");
    endtask

    task automatic test_outstanding();
        lsu_exc_t    e;
        lsu_rd_t     got;
        lsu_rd_t     exp;
        logic [31:0] data;
        start_test();
        for (int k = 0; k < MAX_OR; k++) begin
            issue_instr(make_instr(OPCODE_LOAD, F3_W, 5'(20 + k), 12'(4 * k),
                                   32'h7000_0000, 32'h0), e);
            accept_ar("outstanding load address", 32'h7000_0000 + 32'(4 * k));
        end
        #1;
        check_true("instr_ready high with all reads in flight", !instr_ready);
        check_true("pending_read low with reads in flight", pending_read);
        for (int k = 0; k < MAX_OR; k++) begin
            rand_word(data);
            return_r(data, got);
            exp.wr   = 1'b1;
            exp.addr = 5'(20 + k);
            exp.val  = data;
            check_rd($sformatf("outstanding completion %0d", k), exp, got);
        end
        check_true("pending_read still high after the last completion", !pending_read);
        end_test("outstanding");
    endtask

    //////////////////////
    // Run control
    //////////////////////

    initial begin
        #(N_TESTS * TEST_CYCLES * PERIOD + 20 * PERIOD);
        $display("Error: watchdog expired, the DUT stopped responding");
        $display("tests failed");
        $finish;
    end

    initial begin
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        lfsr        = 32'h4f55;
        instr_valid = 1'b0;
        instr       = '0;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        bresp       = 2'b00;
        arready     = 1'b0;
        rvalid      = 1'b0;
        rdata       = '0;
        rresp       = 2'b00;
        @(posedge aresetn);
        test_stores();
        test_loads();
        test_misaligned();
        test_ordering();
        test_backpressure();
        test_outstanding();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_execute.sv
hdl/lsu_fifo.sv
hdl/lsu_result.sv
hdl/lsu_top.sv
verification/tb_clock.sv
verification/tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
